// File: design/addrgen_burst_exec.sv
/* Walks a decoded vector request and offers one AXI address request at a
   time. Unit-stride requests become INCR bursts, strided ones single beats. */

`include "addrgen_params.svh"

module addrgen_burst_exec
  import addrgen_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  walk_req_t walk_req_i,
  input  logic      walk_start_i,
  input  logic      ax_fire_i,
  output ax_req_t   ax_req_o,
  output logic      ax_is_load_o,
  output logic      ax_valid_o,
  output logic      walk_done_o
);

  // Last byte of the next burst, limited by length, burst size and page
  function automatic addr_t plan_end(addr_t addr, vlen_t rem, vew_e vew);
    addr_t start;
    addr_t last;
    addr_t cap;
    addr_t end_a;
    start = addr & ~addr_t'(`BUS_BYTES - 1);
    last  = addr + (addr_t'(rem) << vew) - addr_t'(1);
    end_a = last | addr_t'(`BUS_BYTES - 1);
    cap   = start + addr_t'(`MAX_BURST * `BUS_BYTES) - addr_t'(1);
    if (cap < end_a) begin
      end_a = cap;
    end
    if ((end_a >> `PAGE_BITS) != (start >> `PAGE_BITS)) begin
      end_a = start | addr_t'((1 << `PAGE_BITS) - 1);
    end
    return end_a;
  endfunction

  walk_state_e state_q, state_d;
  walk_req_t   walk_q, walk_d;
  addr_t       end_q, end_d;
  addr_t       aligned_start;
  addr_t       beat_span;
  addr_t       consumed;

  ////////////////////////////////////////
  // Request offered on the channel
  ////////////////////////////////////////

  assign aligned_start = walk_q.addr & ~addr_t'(`BUS_BYTES - 1);
  assign beat_span     = (end_q - aligned_start) >> `BUS_SIZE_LOG;
  // Elements covered from the current address up to the burst end
  assign consumed      = (end_q - walk_q.addr + addr_t'(1)) >> walk_q.vew;

  always_comb begin
    if (walk_q.is_burst) begin
      ax_req_o = '{
        addr: walk_q.addr,
        len:  ax_len_t'(beat_span),
        size: ax_size_t'(`BUS_SIZE_LOG)
      };
    end else begin
      ax_req_o = '{
        addr: walk_q.addr,
        len:  '0,
        size: ax_size_t'(walk_q.vew)
      };
    end
  end

  assign ax_valid_o   = (state_q == W_REQ);
  assign ax_is_load_o = walk_q.is_load;

  ////////////////////////////////////////
  // Walk FSM
  ////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    walk_d      = walk_q;
    end_d       = end_q;
    walk_done_o = 1'b0;
    case (state_q)
      W_IDLE: begin
        if (walk_start_i) begin
          walk_d  = walk_req_i;
          state_d = W_PLAN;
        end
      end
      W_PLAN: begin
        end_d   = plan_end(walk_q.addr, walk_q.len, walk_q.vew);
        state_d = W_REQ;
      end
      W_REQ: begin
        if (ax_fire_i) begin
          if (walk_q.is_burst) begin
            // Last burst may run past the vector end
            if (addr_t'(walk_q.len) <= consumed) begin
              walk_d.len = '0;
            end else begin
              walk_d.len = walk_q.len - vlen_t'(consumed);
            end
            walk_d.addr = end_q + addr_t'(1);
            end_d       = plan_end(walk_d.addr, walk_d.len, walk_q.vew);
          end else begin
            walk_d.len  = walk_q.len - vlen_t'(1);
            walk_d.addr = walk_q.addr + addr_t'(walk_q.stride);
          end
          if (walk_d.len == '0) begin
            walk_done_o = 1'b1;
            state_d     = W_IDLE;
          end
        end
      end
      default: state_d = W_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    walk_q <= walk_d;
    end_q  <= end_d;
  end

  // Offered request holds until it transfers
  a_hold_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ax_valid_o && !ax_fire_i |=> ax_valid_o && $stable(ax_req_o));

endmodule

// File: design/addrgen_decode.sv
/* Request front end. Accepts one vector request while idle, checks element
   alignment, hands good requests to the walker and acknowledges the end. */

module addrgen_decode
  import addrgen_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  vec_req_t  vec_req_i,
  input  logic      req_valid_i,
  input  logic      walk_done_i,
  output walk_req_t walk_req_o,
  output logic      walk_start_o,
  output logic      ack_o,
  output logic      error_o
);

  decode_state_e state_q, state_d;
  vec_req_t      req_q;
  addr_t         elem_mask;
  logic          misaligned;
  logic          ack_d, error_d;

  // Low address bits that must be zero for the element width
  assign elem_mask  = (addr_t'(1) << req_q.vew) - addr_t'(1);
  assign misaligned = |(req_q.addr & elem_mask);

  assign walk_req_o = '{
    addr:     req_q.addr,
    len:      req_q.vl,
    stride:   req_q.stride,
    vew:      req_q.vew,
    is_load:  (req_q.op == OP_VLE) || (req_q.op == OP_VLSE),
    is_burst: (req_q.op == OP_VLE) || (req_q.op == OP_VSE)
  };

  always_comb begin
    state_d      = state_q;
    ack_d        = 1'b0;
    error_d      = 1'b0;
    walk_start_o = 1'b0;
    case (state_q)
      IDLE: begin
        if (req_valid_i) begin
          state_d = CHECK;
        end
      end
      CHECK: begin
        if (misaligned) begin
          ack_d   = 1'b1;
          error_d = 1'b1;
          state_d = IDLE;
        end else if (req_q.vl == '0) begin
          // Nothing to move, just acknowledge
          ack_d   = 1'b1;
          state_d = IDLE;
        end else begin
          walk_start_o = 1'b1;
          state_d      = BUSY;
        end
      end
      BUSY: begin
        if (walk_done_i) begin
          ack_d   = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
      error_o <= 1'b0;
    end else begin
      state_q <= state_d;
      ack_o   <= ack_d;
      error_o <= error_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_valid_i) begin
      req_q <= vec_req_i;
    end
  end

  // An error is always an ack, and only ever right after a check
  a_error_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    error_o |-> ack_o && $past(state_q == CHECK));

endmodule

// File: design/addrgen_issue.sv
/* Drives the offered address request on AR or AW and mirrors every transfer
   into the load/store command queue. Keeps the two channels in order. */

`include "addrgen_params.svh"

module addrgen_issue
  import addrgen_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  ax_req_t ax_req_i,
  input  logic    ax_is_load_i,
  input  logic    ax_valid_i,
  input  logic    ar_ready_i,
  input  logic    aw_ready_i,
  input  logic    ls_cmd_pop_i,
  output logic    ax_fire_o,
  output ax_req_t ar_o,
  output ax_req_t aw_o,
  output logic    ar_valid_o,
  output logic    aw_valid_o,
  output ls_cmd_t ls_cmd_o,
  output logic    ls_cmd_valid_o
);

  localparam int PTR_W = $clog2(`CMD_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  ls_cmd_t            queue_mem [`CMD_DEPTH];
  logic   [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic   [CNT_W-1:0] count_q;
  logic               full, empty;
  logic               dir_ok, offer, ch_ready;
  logic               push, pop;

  assign full  = (count_q == CNT_W'(`CMD_DEPTH));
  assign empty = (count_q == '0);

  ////////////////////////////////////////
  // Channel steering
  ////////////////////////////////////////

  // Queue holds one direction only, so the head decides
  assign dir_ok   = empty || (ls_cmd_o.is_load == ax_is_load_i);
  assign offer    = ax_valid_i && dir_ok && !full;
  assign ch_ready = ax_is_load_i ? ar_ready_i : aw_ready_i;

  assign ar_o       = ax_req_i;
  assign aw_o       = ax_req_i;
  assign ar_valid_o = offer && ax_is_load_i;
  assign aw_valid_o = offer && !ax_is_load_i;
  assign ax_fire_o  = offer && ch_ready;

  ////////////////////////////////////////
  // Command queue
  ////////////////////////////////////////

  assign push           = ax_fire_o;
  assign pop            = ls_cmd_pop_i && !empty;
  assign ls_cmd_o       = queue_mem[rd_ptr_q];
  assign ls_cmd_valid_o = !empty;

  always_ff @(posedge clk_i) begin
    if (push) begin
      queue_mem[wr_ptr_q] <= '{
        addr:    ax_req_i.addr,
        len:     ax_req_i.len,
        size:    ax_req_i.size,
        is_load: ax_is_load_i
      };
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + PTR_W'(1);
      end
      count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push |-> !full);

  // AXI rule: valid stays up until ready, across queue pops
  a_ar_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_o && !ar_ready_i |=> ar_valid_o);
  a_aw_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_o && !aw_ready_i |=> aw_valid_o);

endmodule

// File: design/addrgen_params.svh
/* Bus, page and queue constants of the vector address generator.
   Included by the package and by every module that needs a constant. */

`ifndef ADDRGEN_PARAMS_SVH
`define ADDRGEN_PARAMS_SVH

// Address and vector length widths
`define ADDR_W 32
`define VLEN_W 16

// 64-bit data bus
`define BUS_BYTES    8
`define BUS_SIZE_LOG 3

// AXI burst and page limits
`define MAX_BURST 256
`define PAGE_BITS 12

// Load/store command queue
`define CMD_DEPTH 4

`endif

// File: design/addrgen_pkg.sv
/* Shared types of the vector address generator.
   Modules pick them up with a wildcard import in the module header. */

`include "addrgen_params.svh"

package addrgen_pkg;

  typedef logic        [`ADDR_W-1:0] addr_t;
  typedef logic        [`VLEN_W-1:0] vlen_t;
  typedef logic signed [`ADDR_W-1:0] stride_t;
  typedef logic        [7:0]         ax_len_t;
  typedef logic        [2:0]         ax_size_t;

  typedef enum logic [1:0] {EW8, EW16, EW32, EW64} vew_e;

  // Unit load, unit store, strided load, strided store
  typedef enum logic [1:0] {OP_VLE, OP_VSE, OP_VLSE, OP_VSSE} mem_op_e;

  typedef struct packed {
    mem_op_e op;
    addr_t   addr;
    vlen_t   vl;
    vew_e    vew;
    stride_t stride;
  } vec_req_t;

  // Len counts remaining elements while the request is walked
  typedef struct packed {
    addr_t   addr;
    vlen_t   len;
    stride_t stride;
    vew_e    vew;
    logic    is_load;
    logic    is_burst;
  } walk_req_t;

  typedef struct packed {
    addr_t    addr;
    ax_len_t  len;
    ax_size_t size;
  } ax_req_t;

  typedef struct packed {
    addr_t    addr;
    ax_len_t  len;
    ax_size_t size;
    logic     is_load;
  } ls_cmd_t;

  typedef enum logic [1:0] {IDLE, CHECK, BUSY} decode_state_e;
  typedef enum logic [1:0] {W_IDLE, W_PLAN, W_REQ} walk_state_e;

endpackage

// File: design/addrgen_top.sv
/* Vector memory address generator. Takes one load or store request at a
   time and issues AXI AR/AW requests plus load/store unit commands. */

module addrgen_top
  import addrgen_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  vec_req_t vec_req_i,
  input  logic     req_valid_i,
  output logic     ack_o,
  output logic     error_o,
  output ax_req_t  ar_o,
  output logic     ar_valid_o,
  input  logic     ar_ready_i,
  output ax_req_t  aw_o,
  output logic     aw_valid_o,
  input  logic     aw_ready_i,
  output ls_cmd_t  ls_cmd_o,
  output logic     ls_cmd_valid_o,
  input  logic     ls_cmd_pop_i
);

  walk_req_t walk_req;
  logic      walk_start;
  logic      walk_done;
  ax_req_t   ax_req;
  logic      ax_is_load;
  logic      ax_valid;
  logic      ax_fire;

  addrgen_decode u_decode (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .vec_req_i    (vec_req_i),
    .req_valid_i  (req_valid_i),
    .walk_done_i  (walk_done),
    .walk_req_o   (walk_req),
    .walk_start_o (walk_start),
    .ack_o        (ack_o),
    .error_o      (error_o)
  );

  addrgen_burst_exec u_exec (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .walk_req_i   (walk_req),
    .walk_start_i (walk_start),
    .ax_fire_i    (ax_fire),
    .ax_req_o     (ax_req),
    .ax_is_load_o (ax_is_load),
    .ax_valid_o   (ax_valid),
    .walk_done_o  (walk_done)
  );

  addrgen_issue u_issue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .ax_req_i       (ax_req),
    .ax_is_load_i   (ax_is_load),
    .ax_valid_i     (ax_valid),
    .ar_ready_i     (ar_ready_i),
    .aw_ready_i     (aw_ready_i),
    .ls_cmd_pop_i   (ls_cmd_pop_i),
    .ax_fire_o      (ax_fire),
    .ar_o           (ar_o),
    .aw_o           (aw_o),
    .ar_valid_o     (ar_valid_o),
    .aw_valid_o     (aw_valid_o),
    .ls_cmd_o       (ls_cmd_o),
    .ls_cmd_valid_o (ls_cmd_valid_o)
  );

endmodule

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module addrgen_tb -Mdir obj_dir -f tb.f > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vaddrgen_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION PASSED" sim.log; then
  exit 0
fi
exit 1

// File: tb.f
+incdir+design
design/addrgen_pkg.sv
design/addrgen_decode.sv
design/addrgen_burst_exec.sv
design/addrgen_issue.sv
design/addrgen_top.sv
testbench/tb_clock.sv
testbench/addrgen_checker.sv
testbench/addrgen_tb.sv

// File: testbench/addrgen_cases.txt
# op addr vl vew stride, all hex, one request per line
# op 0 unit load, 1 unit store, 2 strided load, 3 strided store; vew 0..3 is 8..64 bits
0 00001010 0020 2 00000000
0 00002004 0005 2 00000000
1 00003f80 0080 1 00000000
0 00010000 0200 3 00000000
3 00005000 0006 2 00000040
0 00007002 0008 2 00000000
2 00006000 0004 3 fffffff0
1 00009001 0004 1 00000000
0 00008003 000d 0 00000000
1 0000a000 0000 0 00000000
3 0000b001 0005 0 00000003
1 0000cff0 0104 3 00000000
0 0000d800 0180 3 00000000
2 0000e000 0003 1 00000100
1 00020000 0101 3 00000000
0 00030ff8 0004 3 00000000
3 00040000 0004 3 00000008
0 00050100 0010 1 00000000
1 00060006 0007 1 00000000
0 00070004 0003 3 00000000

// File: testbench/addrgen_checker.sv
/* Reference model and comparator for the address generator. Predicts the
   requests of every accepted vector request and checks transfers and pops. */

`include "addrgen_params.svh"

module addrgen_checker
  import addrgen_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  vec_req_t vec_req_i,
  input  logic     req_valid_i,
  input  logic     ack_i,
  input  logic     error_i,
  input  ax_req_t  ar_i,
  input  logic     ar_valid_i,
  input  logic     ar_ready_i,
  input  ax_req_t  aw_i,
  input  logic     aw_valid_i,
  input  logic     aw_ready_i,
  input  ls_cmd_t  ls_cmd_i,
  input  logic     ls_cmd_valid_i,
  input  logic     ls_cmd_pop_i,
  output int       err_cnt_o,
  output int       pending_o
);
  timeunit 1ns;
  timeprecision 100ps;

  ls_cmd_t exp_ax[$];
  ls_cmd_t exp_pop[$];
  // Direction of every command the DUT queue should hold
  logic    held_load[$];
  logic    exp_err      = 1'b0;
  logic    in_reset     = 1'b1;
  int      cycle        = 0;
  int      accept_cycle = 0;
  int      errors       = 0;
  int      pending      = 0;

  assign err_cnt_o = errors;
  assign pending_o = pending;

  ////////////////////////////////////////
  // Prediction
  ////////////////////////////////////////

  task automatic predict(input vec_req_t req);
    int unsigned eb;
    int unsigned left;
    int unsigned offs;
    int unsigned pg_off;
    int unsigned need;
    int unsigned room;
    int unsigned beats;
    int unsigned taken;
    int          k;
    addr_t       addr;
    addr_t       start;
    addr_t       next;
    ls_cmd_t     cmd;
    logic        is_load;
    eb      = 32'd1 << req.vew;
    is_load = (req.op == OP_VLE) || (req.op == OP_VLSE);
    exp_err = (req.addr & addr_t'(eb - 1)) != '0;
    if (!exp_err && (req.op == OP_VLE || req.op == OP_VSE)) begin
      // Counted in whole bus beats and limited by burst size and page room
      addr = req.addr;
      left = 32'(req.vl);
      while (left != 0) begin
        start  = addr & ~addr_t'(`BUS_BYTES - 1);
        offs   = addr - start;
        pg_off = start & addr_t'((1 << `PAGE_BITS) - 1);
        need   = (offs + left * eb + `BUS_BYTES - 1) / `BUS_BYTES;
        room   = ((1 << `PAGE_BITS) - pg_off) / `BUS_BYTES;
        beats  = need;
        if (beats > `MAX_BURST) begin
          beats = `MAX_BURST;
        end
        if (beats > room) begin
          beats = room;
        end
        cmd = '{addr: addr, len: ax_len_t'(beats - 1),
                size: ax_size_t'(`BUS_SIZE_LOG), is_load: is_load};
        exp_ax.push_back(cmd);
        exp_pop.push_back(cmd);
        next  = start + addr_t'(beats * `BUS_BYTES);
        taken = (next - addr) / eb;
        left  = (taken >= left) ? 0 : left - taken;
        addr  = next;
      end
    end else if (!exp_err) begin
      for (k = 0; k < int'(req.vl); k++) begin
        cmd = '{addr: req.addr + addr_t'(k) * addr_t'(req.stride), len: '0,
                size: ax_size_t'(req.vew), is_load: is_load};
        exp_ax.push_back(cmd);
        exp_pop.push_back(cmd);
      end
    end
  endtask

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("ERROR %s after reset: got %h, expected 0", name, value);
      errors++;
    end
  endtask

  task automatic check_transfer(input string name, input ax_req_t got, input logic is_load);
    ls_cmd_t exp;
    logic    crossed;
    crossed = 1'b0;
    foreach (held_load[i]) begin
      if (held_load[i] != is_load) begin
        crossed = 1'b1;
      end
    end
    if (crossed) begin
      $display("Transfer on %s while a command of the other direction is queued", name);
      errors++;
    end
    if (exp_ax.size() == 0) begin
      $display("Unexpected transfer on %s at address %h", name, got.addr);
      errors++;
    end else begin
      exp = exp_ax.pop_front();
      if (exp.is_load != is_load) begin
        $display("Request went out on %s, the other channel was expected", name);
        errors++;
      end else if (got.addr !== exp.addr || got.len !== exp.len || got.size !== exp.size) begin
        $display("ERROR %s: got addr %h len %h size %h, expected addr %h len %h size %h",
                 name, got.addr, got.len, got.size, exp.addr, exp.len, exp.size);
        errors++;
      end
    end
  endtask

  task automatic check_pop();
    ls_cmd_t exp;
    if (exp_pop.size() == 0) begin
      $display("A command was popped that was never predicted");
      errors++;
    end else begin
      exp = exp_pop.pop_front();
      if (ls_cmd_i !== exp) begin
        $display("ERROR ls_cmd_o: got %h, expected %h", ls_cmd_i, exp);
        errors++;
      end
    end
    if (held_load.size() != 0) begin
      held_load.delete(0);
    end
  endtask

  task automatic check_ack();
    if (error_i !== exp_err) begin
      $display("ERROR error_o: got %h, expected %h", error_i, exp_err);
      errors++;
    end
    if (exp_err && (cycle - accept_cycle != 2)) begin
      $display("Error ack came %0d cycles after the accept edge instead of 2",
               cycle - accept_cycle);
      errors++;
    end
    if (exp_ax.size() != 0) begin
      $display("Ack while %0d address requests are still missing", exp_ax.size());
      errors++;
    end
  endtask

  always @(posedge clk_i) begin
    logic fired;
    logic fired_load;
    fired      = 1'b0;
    fired_load = 1'b0;
    cycle++;
    if (!rst_ni) begin
      in_reset = 1'b1;
    end else begin
      if (in_reset) begin
        check_low("ack_o", ack_i);
        check_low("error_o", error_i);
        check_low("ar_valid_o", ar_valid_i);
        check_low("aw_valid_o", aw_valid_i);
        check_low("ls_cmd_valid_o", ls_cmd_valid_i);
        in_reset = 1'b0;
      end
      if (ls_cmd_valid_i !== (held_load.size() != 0)) begin
        $display("ERROR ls_cmd_valid_o: got %h, expected %h",
                 ls_cmd_valid_i, held_load.size() != 0);
        errors++;
      end
      if (req_valid_i) begin
        predict(vec_req_i);
        accept_cycle = cycle;
      end
      if (ar_valid_i && ar_ready_i) begin
        check_transfer("ar_o", ar_i, 1'b1);
        fired      = 1'b1;
        fired_load = 1'b1;
      end
      if (aw_valid_i && aw_ready_i) begin
        check_transfer("aw_o", aw_i, 1'b0);
        fired = 1'b1;
      end
      // Pop sees the head before this cycle's push
      if (ls_cmd_valid_i && ls_cmd_pop_i) begin
        check_pop();
      end
      if (fired) begin
        held_load.push_back(fired_load);
      end
      if (ack_i) begin
        check_ack();
      end
      pending = exp_ax.size() + exp_pop.size();
    end
  end

endmodule

// File: testbench/addrgen_tb.sv
/* Top testbench of the address generator. Reads one request per line from
   the case file, drives it on a falling edge and waits for the ack. */

module addrgen_tb
  import addrgen_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ACK_TIMEOUT   = 2000;
  localparam int DRAIN_TIMEOUT = 2000;
  localparam int RESET_TIMEOUT = 20;
  localparam int QUIET_CYCLES  = 20;

  logic     clk;
  logic     rst_n;
  vec_req_t vec_req    = '0;
  logic     req_valid  = 1'b0;
  logic     ar_ready   = 1'b0;
  logic     aw_ready   = 1'b0;
  logic     ls_cmd_pop = 1'b0;
  logic     ack;
  logic     dut_error;
  ax_req_t  ar;
  ax_req_t  aw;
  logic     ar_valid;
  logic     aw_valid;
  ls_cmd_t  ls_cmd;
  logic     ls_cmd_valid;
  int       err_cnt;
  int       pending;
  integer   seed      = 32'h457f;
  int       cases_run = 0;
  int       cases_bad = 0;
  logic     aborted   = 1'b0;

  tb_clock u_clock (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  addrgen_top uut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .vec_req_i      (vec_req),
    .req_valid_i    (req_valid),
    .ack_o          (ack),
    .error_o        (dut_error),
    .ar_o           (ar),
    .ar_valid_o     (ar_valid),
    .ar_ready_i     (ar_ready),
    .aw_o           (aw),
    .aw_valid_o     (aw_valid),
    .aw_ready_i     (aw_ready),
    .ls_cmd_o       (ls_cmd),
    .ls_cmd_valid_o (ls_cmd_valid),
    .ls_cmd_pop_i   (ls_cmd_pop)
  );

  addrgen_checker u_checker (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .vec_req_i      (vec_req),
    .req_valid_i    (req_valid),
    .ack_i          (ack),
    .error_i        (dut_error),
    .ar_i           (ar),
    .ar_valid_i     (ar_valid),
    .ar_ready_i     (ar_ready),
    .aw_i           (aw),
    .aw_valid_i     (aw_valid),
    .aw_ready_i     (aw_ready),
    .ls_cmd_i       (ls_cmd),
    .ls_cmd_valid_i (ls_cmd_valid),
    .ls_cmd_pop_i   (ls_cmd_pop),
    .err_cnt_o      (err_cnt),
    .pending_o      (pending)
  );

  // Slave ready and queue pop levels change on every falling edge
  always @(negedge clk) begin
    if (rst_n) begin
      ar_ready   = ($random(seed) & 3) != 0;
      aw_ready   = ($random(seed) & 3) != 0;
      ls_cmd_pop = ($random(seed) & 1) != 0;
    end
  end

  // A fatal problem stops the case flow and ends the run as failed
  task automatic abort_run(input string why);
    $display("%s", why);
    aborted = 1'b1;
  endtask

  task automatic run_case(input int idx, input vec_req_t req);
    int    cyc;
    int    errs_before;
    string verdict;
    errs_before = err_cnt;
    @(negedge clk);
    vec_req   = req;
    req_valid = 1'b1;
    @(negedge clk);
    req_valid = 1'b0;
    cyc = 0;
    while (!ack && !aborted) begin
      @(negedge clk);
      cyc++;
      if (cyc > ACK_TIMEOUT) begin
        abort_run($sformatf("No ack_o for case %0d within %0d cycles", idx, ACK_TIMEOUT));
      end
    end
    if (aborted) begin
      return;
    end
    // Give a stray transfer time to show up after an error
    if (dut_error) begin
      repeat (QUIET_CYCLES) @(negedge clk);
    end
    cases_run++;
    if (err_cnt == errs_before) begin
      verdict = "ok";
    end else begin
      verdict = $sformatf("%0d mismatches", err_cnt - errs_before);
      cases_bad++;
    end
    $display("case %0d op %0d addr %h vl %h vew %0d error %0d: %s",
             idx, req.op, req.addr, req.vl, req.vew, dut_error, verdict);
  endtask

  initial begin
    int          fd;
    int          n;
    int          idx;
    int          cyc;
    int          bad_lines;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_addr;
    logic [31:0] f_vl;
    logic [31:0] f_vew;
    logic [31:0] f_stride;
    vec_req_t    req;
    idx       = 0;
    bad_lines = 0;
    cyc       = 0;
    fd        = 0;
    while (rst_n !== 1'b1 && !aborted) begin
      @(negedge clk);
      cyc++;
      if (cyc > RESET_TIMEOUT) begin
        abort_run("Reset was never released");
      end
    end
    if (!aborted) begin
      fd = $fopen("testbench/addrgen_cases.txt", "r");
      if (fd == 0) begin
        abort_run("Cannot open testbench/addrgen_cases.txt");
      end
    end
    while (!aborted) begin
      if ($fgets(line, fd) == 0) begin
        break;
      end
      if (line.len() < 2 || line[0] == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_vl, f_vew, f_stride);
      if (n != 5) begin
        $display("Case file line could not be read: %s", line);
        bad_lines++;
      end else begin
        req.op     = mem_op_e'(f_op[1:0]);
        req.addr   = f_addr;
        req.vl     = vlen_t'(f_vl);
        req.vew    = vew_e'(f_vew[1:0]);
        req.stride = stride_t'(f_stride);
        idx++;
        run_case(idx, req);
      end
    end
    if (fd != 0) begin
      $fclose(fd);
    end

    // Let the load/store units take every remaining command
    cyc = 0;
    while (ls_cmd_valid && !aborted) begin
      @(negedge clk);
      cyc++;
      if (cyc > DRAIN_TIMEOUT) begin
        abort_run("Command queue did not drain");
      end
    end
    @(negedge clk);
    if (pending != 0) begin
      $display("%0d predicted requests or commands never appeared", pending);
    end
    $display("cases %0d, ok %0d, bad %0d, checker errors %0d, unread lines %0d",
             cases_run, cases_run - cases_bad, cases_bad, err_cnt, bad_lines);
    if (!aborted && cases_bad == 0 && err_cnt == 0 && bad_lines == 0 &&
        pending == 0 && idx > 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: testbench/tb_clock.sv
/* Clock and reset for the testbench. A 4 ns clock, and an active-low reset
   that is released on a falling edge after four cycles. */

module tb_clock (
  output logic clk_o,
  output logic rst_no
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule
